// File: hw/timetag_pkg.sv
`default_nettype none

package timetag_pkg;

	// Channel and timestamp geometry
	localparam int N_CH = 4;
	localparam int CH_W = 2;
	localparam int TIME_W = 24;

	typedef logic [TIME_W-1:0] time_t;
	typedef logic [7:0] byte_t;
	typedef logic [CH_W-1:0] ch_t;

	// Command framing
	localparam byte_t CMD_SYNC = 8'hAA;
	localparam byte_t OP_READ = 8'h00;
	localparam byte_t OP_WRITE = 8'h01;

	// Register map
	localparam byte_t REG_VERSION = 8'h01;
	localparam byte_t REG_CLOCK = 8'h02;
	localparam byte_t REG_CONTROL = 8'h03;
	localparam byte_t REG_MASK = 8'h04;

	// Read-only register contents
	localparam byte_t VERSION = 8'h01;
	localparam byte_t CLOCK_MHZ = 8'd100;

	// Control register bits
	localparam int CTL_CAPTURE = 0;
	localparam int CTL_COUNT = 1;
	localparam int CTL_CLEAR = 2;

	// Overflow flag in the first record byte
	localparam int LOST_BIT = 7;

	typedef enum logic [1:0] {
		CMD_IDLE,
		CMD_OP,
		CMD_ADDR,
		CMD_VALUE
	} cmd_state_t;

	typedef enum logic [2:0] {
		MRG_SCAN,
		MRG_BYTE0,
		MRG_BYTE1,
		MRG_BYTE2,
		MRG_BYTE3
	} merge_state_t;

endpackage

`default_nettype wire

// File: hw/tag_if.sv
`timescale 1ns/1ps
`default_nettype none

// One channel's pending stamp, offered to the merger
interface tag_if import timetag_pkg::*; ();

	logic hit;
	time_t tag;
	logic lost;
	logic take;

	modport source (
		output hit,
		output tag,
		output lost,
		input take
	);

	modport sink (
		input hit,
		input tag,
		input lost,
		output take
	);

endinterface

`default_nettype wire

// File: hw/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder import timetag_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire byte_t cmd_data,
	input wire logic cmd_wr,
	output byte_t reply_data,
	output logic reply_wr,
	output logic capture,
	output logic count_en,
	output logic count_clear,
	output logic [N_CH-1:0] mask
);

	cmd_state_t state;
	byte_t op_q;
	byte_t addr_q;

	logic frame_done;
	logic is_write;
	logic next_capture;
	logic next_count;
	logic next_clear;
	logic [N_CH-1:0] next_mask;
	byte_t reply_next;

	assign frame_done = cmd_wr && (state == CMD_VALUE);
	// Anything other than a write op is handled as a read
	assign is_write = (op_q == OP_WRITE);

	// Register values as they stand after the current frame
	always_comb begin
		next_capture = capture;
		next_count = count_en;
		next_clear = 1'b0;
		next_mask = mask;
		if (is_write && addr_q == REG_CONTROL) begin
			next_capture = cmd_data[CTL_CAPTURE];
			next_count = cmd_data[CTL_COUNT];
			next_clear = cmd_data[CTL_CLEAR];
		end
		if (is_write && addr_q == REG_MASK)
			next_mask = cmd_data[N_CH-1:0];

		reply_next = '0;
		case (addr_q)
			REG_VERSION: reply_next = VERSION;
			REG_CLOCK: reply_next = CLOCK_MHZ;
			REG_CONTROL: begin
				reply_next[CTL_CAPTURE] = next_capture;
				reply_next[CTL_COUNT] = next_count;
			end
			REG_MASK: reply_next = byte_t'(next_mask);
			default: reply_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CMD_IDLE;
			capture <= 1'b0;
			count_en <= 1'b0;
			count_clear <= 1'b0;
			mask <= '0;
			reply_wr <= 1'b0;
		end else begin
			reply_wr <= 1'b0;
			count_clear <= 1'b0;
			if (cmd_wr) begin
				case (state)
					// Wait here until a sync byte shows up
					CMD_IDLE: if (cmd_data == CMD_SYNC) state <= CMD_OP;
					CMD_OP: state <= CMD_ADDR;
					CMD_ADDR: state <= CMD_VALUE;
					CMD_VALUE: begin
						capture <= next_capture;
						count_en <= next_count;
						count_clear <= next_clear;
						mask <= next_mask;
						reply_wr <= 1'b1;
						state <= CMD_IDLE;
					end
					default: state <= CMD_IDLE;
				endcase
			end
		end
	end

	// Frame fields and reply byte
	always_ff @(posedge clk) begin
		if (cmd_wr && state == CMD_OP)
			op_q <= cmd_data;
		if (cmd_wr && state == CMD_ADDR)
			addr_q <= cmd_data;
		if (frame_done)
			reply_data <= reply_next;
	end

endmodule

`default_nettype wire

// File: hw/strobe_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module strobe_frontend import timetag_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic [N_CH-1:0] strobe_in,
	input wire logic capture,
	input wire logic count_en,
	input wire logic count_clear,
	input wire logic [N_CH-1:0] mask,
	output logic [N_CH-1:0] edges,
	output time_t now
);

	logic [N_CH-1:0] sync_a;
	logic [N_CH-1:0] sync_b;
	logic [N_CH-1:0] sync_prev;
	time_t count_q;

	// Two-stage synchronizer plus one delayed copy for edge detection
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_a <= '0;
			sync_b <= '0;
			sync_prev <= '0;
		end else begin
			sync_a <= strobe_in;
			sync_b <= sync_a;
			sync_prev <= sync_b;
		end
	end

	// Rising edges, only on enabled channels while capturing
	assign edges = sync_b & ~sync_prev & mask & {N_CH{capture}};

	// Free-running timestamp counter
	always_ff @(posedge clk) begin
		if (rst)
			count_q <= '0;
		else if (count_clear)
			count_q <= '0;
		else if (count_en)
			count_q <= count_q + 1'b1;
	end

	// Stamp seen by the taggers in the same cycle as the edge
	assign now = count_q;

endmodule

`default_nettype wire

// File: hw/channel_tagger.sv
`timescale 1ns/1ps
`default_nettype none

module channel_tagger import timetag_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic edge_seen,
	input wire time_t now,
	tag_if.source tag_out
);

	logic hit_q;
	logic lost_q;
	time_t tag_q;
	logic accept;

	// Hold is free, or is being emptied in this very cycle
	assign accept = edge_seen && (!hit_q || tag_out.take);

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= 1'b0;
			lost_q <= 1'b0;
		end else if (tag_out.take) begin
			hit_q <= edge_seen;
			lost_q <= 1'b0;
		end else if (edge_seen) begin
			// Full hold drops the new edge and remembers it
			if (hit_q)
				lost_q <= 1'b1;
			else
				hit_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			tag_q <= now;
	end

	assign tag_out.hit = hit_q;
	assign tag_out.lost = lost_q;
	assign tag_out.tag = tag_q;

endmodule

`default_nettype wire

// File: hw/record_merger.sv
`timescale 1ns/1ps
`default_nettype none

module record_merger import timetag_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	tag_if.sink tags [N_CH],
	output byte_t ev_data,
	output logic ev_wr,
	input wire logic ev_full
);

	logic [N_CH-1:0] hit_vec;
	logic [N_CH-1:0] lost_vec;
	logic [N_CH-1:0] take_vec;
	time_t tag_vec [N_CH];

	merge_state_t state;
	ch_t last_ch;
	ch_t pick;
	logic found;
	logic grab;

	ch_t rec_ch;
	logic rec_lost;
	time_t rec_tag;

	// Flatten the interface array so channels can be indexed at run time
	for (genvar i = 0; i < N_CH; i++) begin : g_flat
		assign hit_vec[i] = tags[i].hit;
		assign lost_vec[i] = tags[i].lost;
		assign tag_vec[i] = tags[i].tag;
		assign tags[i].take = take_vec[i];
	end

	// Round-robin search, starting one past the channel served last
	always_comb begin : rr_pick
		ch_t idx;
		found = 1'b0;
		pick = last_ch;
		for (int k = 1; k <= N_CH; k++) begin
			idx = last_ch + ch_t'(k);
			if (!found && hit_vec[idx]) begin
				found = 1'b1;
				pick = idx;
			end
		end
	end

	// A pending stamp stays in its tagger while the output is full
	assign grab = (state == MRG_SCAN) && found && !ev_full;

	// Take goes out in the cycle the record is latched
	always_comb begin
		take_vec = '0;
		if (grab)
			take_vec[pick] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MRG_SCAN;
			last_ch <= ch_t'(N_CH - 1);
		end else begin
			case (state)
				MRG_SCAN: begin
					if (grab) begin
						state <= MRG_BYTE0;
						last_ch <= pick;
					end
				end
				// Each byte waits for room in the output FIFO
				MRG_BYTE0: if (!ev_full) state <= MRG_BYTE1;
				MRG_BYTE1: if (!ev_full) state <= MRG_BYTE2;
				MRG_BYTE2: if (!ev_full) state <= MRG_BYTE3;
				MRG_BYTE3: if (!ev_full) state <= MRG_SCAN;
				default: state <= MRG_SCAN;
			endcase
		end
	end

	// Record being serialized
	always_ff @(posedge clk) begin
		if (grab) begin
			rec_ch <= pick;
			rec_lost <= lost_vec[pick];
			rec_tag <= tag_vec[pick];
		end
	end

	always_comb begin
		ev_data = '0;
		case (state)
			MRG_BYTE0: begin
				ev_data[CH_W-1:0] = rec_ch;
				ev_data[LOST_BIT] = rec_lost;
			end
			// Stamp goes most significant byte first
			MRG_BYTE1: ev_data = rec_tag[TIME_W-1 -: 8];
			MRG_BYTE2: ev_data = rec_tag[TIME_W-9 -: 8];
			MRG_BYTE3: ev_data = rec_tag[7:0];
			default: ev_data = '0;
		endcase
	end

	assign ev_wr = (state != MRG_SCAN) && !ev_full;

endmodule

`default_nettype wire

// File: hw/timetag_top.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_top import timetag_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic [N_CH-1:0] strobe_in,
	input wire byte_t cmd_data,
	input wire logic cmd_wr,
	output byte_t reply_data,
	output logic reply_wr,
	output byte_t ev_data,
	output logic ev_wr,
	input wire logic ev_full
);

	logic capture;
	logic count_en;
	logic count_clear;
	logic [N_CH-1:0] mask;
	logic [N_CH-1:0] edges;
	time_t now;

	tag_if tag_bus [N_CH] ();

	cmd_decoder cmd_decoder_inst (
		.clk(clk),
		.rst(rst),
		.cmd_data(cmd_data),
		.cmd_wr(cmd_wr),
		.reply_data(reply_data),
		.reply_wr(reply_wr),
		.capture(capture),
		.count_en(count_en),
		.count_clear(count_clear),
		.mask(mask)
	);

	strobe_frontend strobe_frontend_inst (
		.clk(clk),
		.rst(rst),
		.strobe_in(strobe_in),
		.capture(capture),
		.count_en(count_en),
		.count_clear(count_clear),
		.mask(mask),
		.edges(edges),
		.now(now)
	);

	// One single-entry tagger per detector channel
	for (genvar i = 0; i < N_CH; i++) begin : g_tagger
		channel_tagger channel_tagger_inst (
			.clk(clk),
			.rst(rst),
			.edge_seen(edges[i]),
			.now(now),
			.tag_out(tag_bus[i])
		);
	end

	record_merger record_merger_inst (
		.clk(clk),
		.rst(rst),
		.tags(tag_bus),
		.ev_data(ev_data),
		.ev_wr(ev_wr),
		.ev_full(ev_full)
	);

endmodule

`default_nettype wire

// File: bench/timetag_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_clkgen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held for three rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: bench/timetag_sva.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_sva import timetag_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic reply_wr,
	input wire logic ev_wr,
	input wire logic ev_full,
	input wire byte_t ev_data
);

	// Number of failed checks, watched by the testbench
	int unsigned fail_count = 0;

	// Outputs quiet once reset has been seen on an edge
	a_reset_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !reply_wr && !ev_wr)
		else begin
			$error("reply_wr or ev_wr high during reset");
			fail_count++;
		end

	a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
		ev_full |-> !ev_wr)
		else begin
			$error("ev_wr high while ev_full is high");
			fail_count++;
		end

	// Held byte may not move while the FIFO stays full
	a_hold_on_full: assert property (@(posedge clk) disable iff (rst)
		ev_full && $past(ev_full) |-> $stable(ev_data))
		else begin
			$error("ev_data changed while ev_full held a record");
			fail_count++;
		end

endmodule

bind timetag_top timetag_sva timetag_sva_inst (
	.clk(clk),
	.rst(rst),
	.reply_wr(reply_wr),
	.ev_wr(ev_wr),
	.ev_full(ev_full),
	.ev_data(ev_data)
);

`default_nettype wire

// File: bench/timetag_tb.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_tb import timetag_pkg::*; ();

	typedef enum int {ROW_BYTE, ROW_CMD, ROW_STROBE, ROW_PAIR, ROW_FULL, ROW_CLEAR} kind_t;

	typedef struct {
		kind_t kind;
		byte_t op;
		int arg;
		byte_t value;
		int expect_v;
	} row_t;

	// Cycles from strobe drive to edge latch, with margin
	localparam int FE_LAT = 4;

	logic clk;
	logic rst;
	logic [N_CH-1:0] strobe_in;
	byte_t cmd_data;
	logic cmd_wr;
	byte_t reply_data;
	logic reply_wr;
	byte_t ev_data;
	logic ev_wr;
	logic ev_full;

	row_t rows[$];
	byte_t reply_q[$];
	byte_t byte_q[$];
	int cyc;
	int reply_cyc;
	int offset;
	bit learned;
	int max_stamp;

	timetag_clkgen timetag_clkgen_inst (.clk(clk), .rst(rst));

	timetag_top timetag_top_inst (
		.clk(clk),
		.rst(rst),
		.strobe_in(strobe_in),
		.cmd_data(cmd_data),
		.cmd_wr(cmd_wr),
		.reply_data(reply_data),
		.reply_wr(reply_wr),
		.ev_data(ev_data),
		.ev_wr(ev_wr),
		.ev_full(ev_full)
	);

	// Monitor for replies and record bytes
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (!rst && reply_wr) begin
			reply_q.push_back(reply_data);
			reply_cyc <= cyc;
		end
		if (!rst && ev_wr)
			byte_q.push_back(ev_data);
	end

	task automatic stop_fail();
		$display("** FAIL **");
		$fatal(1);
	endtask

	// Concurrent checks on the top level count their failures
	always @(negedge clk) begin
		assert (timetag_top_inst.timetag_sva_inst.fail_count == 0) else begin
			$display("A bound assertion on the DUT outputs failed");
			stop_fail();
		end
	end

	function automatic void add_row(kind_t kind, byte_t op, int arg, byte_t value, int expect_v);
		row_t r;
		r.kind = kind;
		r.op = op;
		r.arg = arg;
		r.value = value;
		r.expect_v = expect_v;
		rows.push_back(r);
	endfunction

	task automatic send_byte(byte_t b);
		@(negedge clk);
		cmd_data = b;
		cmd_wr = 1'b1;
	endtask

	task automatic run_cmd(byte_t op, byte_t addr, byte_t value, byte_t expect_v);
		int t;
		byte_t got;
		assert (reply_q.size() == 0) else begin
			$display("A reply arrived for bytes outside a frame");
			stop_fail();
		end
		send_byte(CMD_SYNC);
		send_byte(op);
		send_byte(addr);
		send_byte(value);
		@(negedge clk);
		cmd_wr = 1'b0;
		t = 0;
		while (reply_q.size() == 0) begin
			@(negedge clk);
			t++;
			if (t > 20) begin
				$display("No reply arrived for a command frame");
				stop_fail();
			end
		end
		repeat (3) @(negedge clk);
		assert (reply_q.size() == 1) else begin
			$display("More than one reply arrived for one frame");
			stop_fail();
		end
		got = reply_q.pop_front();
		assert (got == expect_v) else begin
			$display("ERR reply_data addr=%h got=%h exp=%h", addr, got, expect_v);
			stop_fail();
		end
		// Any control write may stop or restart the counter
		if (op == OP_WRITE && addr == REG_CONTROL)
			learned = 1'b0;
	endtask

	task automatic pulse(int ch, output int drive_cyc);
		@(negedge clk);
		strobe_in[ch] = 1'b1;
		drive_cyc = cyc;
		@(negedge clk);
		strobe_in[ch] = 1'b0;
	endtask

	task automatic take_record(output int ch, output bit lost, output int stamp);
		int t;
		byte_t b [4];
		t = 0;
		while (byte_q.size() < 4) begin
			@(negedge clk);
			t++;
			if (t > 200) begin
				$display("Expected record did not arrive in time");
				stop_fail();
			end
		end
		for (int i = 0; i < 4; i++)
			b[i] = byte_q.pop_front();
		ch = int'(b[0][CH_W-1:0]);
		lost = b[0][LOST_BIT];
		stamp = int'({b[1], b[2], b[3]});
	endtask

	task automatic check_record(int ch_exp, bit lost_exp, int drive_cyc, output int stamp);
		int ch;
		bit lost;
		take_record(ch, lost, stamp);
		assert (ch == ch_exp) else begin
			$display("ERR ev_data channel got=%h exp=%h", ch, ch_exp);
			stop_fail();
		end
		assert (lost == lost_exp) else begin
			$display("ERR ev_data lost got=%h exp=%h", lost, lost_exp);
			stop_fail();
		end
		// Stamp minus drive cycle is constant while the counter runs
		if (learned) begin
			assert (stamp == drive_cyc + offset) else begin
				$display("ERR ev_data stamp got=%h exp=%h", stamp, drive_cyc + offset);
				stop_fail();
			end
		end else begin
			offset = stamp - drive_cyc;
			learned = 1'b1;
		end
		if (stamp > max_stamp)
			max_stamp = stamp;
	endtask

	task automatic expect_silence(int cycles);
		for (int t = 0; t < cycles; t++) begin
			@(negedge clk);
			assert (byte_q.size() == 0) else begin
				$display("ERR ev_data unexpected record byte=%h", byte_q[0]);
				stop_fail();
			end
		end
	endtask

	task automatic run_row(row_t r);
		int c1;
		int c2;
		int s1;
		int s2;
		int gap;
		int ch;
		bit lost;
		repeat (2 + $urandom % 8) @(negedge clk);
		case (r.kind)
			ROW_BYTE: begin
				send_byte(r.value);
				@(negedge clk);
				cmd_wr = 1'b0;
			end
			ROW_CMD: run_cmd(r.op, byte_t'(r.arg), r.value, byte_t'(r.expect_v));
			ROW_STROBE: begin
				pulse(r.arg, c1);
				if (r.expect_v == 0)
					expect_silence(60);
				else
					check_record(r.arg, 1'b0, c1, s1);
			end
			ROW_PAIR: begin
				gap = 12 + $urandom % 20;
				pulse(r.arg, c1);
				repeat (gap - 2) @(negedge clk);
				pulse(r.arg, c2);
				check_record(r.arg, 1'b0, c1, s1);
				check_record(r.arg, 1'b0, c2, s2);
				assert (s2 - s1 == gap) else begin
					$display("ERR ev_data stamp gap got=%h exp=%h", s2 - s1, gap);
					stop_fail();
				end
			end
			ROW_FULL: begin
				@(negedge clk);
				ev_full = 1'b1;
				pulse(r.arg, c1);
				repeat (6) @(negedge clk);
				pulse(r.arg, c2);
				expect_silence(30);
				ev_full = 1'b0;
				check_record(r.arg, 1'b1, c1, s1);
				expect_silence(30);
			end
			ROW_CLEAR: begin
				pulse(r.arg, c1);
				take_record(ch, lost, s1);
				assert (ch == r.arg && !lost) else begin
					$display("ERR ev_data channel got=%h exp=%h lost=%h", ch, r.arg, lost);
					stop_fail();
				end
				assert (s1 <= c1 - reply_cyc + FE_LAT && s1 < max_stamp) else begin
					$display("ERR ev_data stamp after clear got=%h max=%h", s1, max_stamp);
					stop_fail();
				end
				offset = s1 - c1;
				learned = 1'b1;
			end
			default: ;
		endcase
	endtask

	// Overall guard against a stuck run
	initial begin
		#2ms;
		$display("Simulation did not finish within its time limit");
		stop_fail();
	end

	initial begin
		int seed;
		int t;
		seed = $urandom(57410);
		strobe_in = '0;
		cmd_data = '0;
		cmd_wr = 1'b0;
		ev_full = 1'b0;
		offset = 0;
		learned = 1'b0;
		max_stamp = 0;

		add_row(ROW_BYTE, OP_READ, 0, 8'hFF, 0);
		add_row(ROW_BYTE, OP_READ, 0, 8'hFF, 0);
		add_row(ROW_BYTE, OP_READ, 0, 8'hFF, 0);
		add_row(ROW_CMD, OP_READ, REG_VERSION, 8'h00, VERSION);
		add_row(ROW_CMD, OP_READ, REG_CLOCK, 8'h00, CLOCK_MHZ);
		add_row(ROW_CMD, OP_WRITE, REG_CONTROL, 8'h07, 8'h03);
		add_row(ROW_CMD, OP_WRITE, REG_MASK, 8'h05, 8'h05);
		add_row(ROW_CMD, OP_READ, REG_MASK, 8'h00, 8'h05);
		add_row(ROW_CMD, OP_READ, 8'h09, 8'h00, 8'h00);
		add_row(ROW_CMD, OP_WRITE, REG_MASK, 8'h0F, 8'h0F);
		for (int ch = 0; ch < N_CH; ch++)
			add_row(ROW_STROBE, OP_READ, ch, 8'h00, 1);
		add_row(ROW_PAIR, OP_READ, 2, 8'h00, 1);
		add_row(ROW_FULL, OP_READ, 1, 8'h00, 2);
		add_row(ROW_CMD, OP_WRITE, REG_MASK, 8'h0E, 8'h0E);
		add_row(ROW_STROBE, OP_READ, 0, 8'h00, 0);
		add_row(ROW_CMD, OP_WRITE, REG_MASK, 8'h0F, 8'h0F);
		add_row(ROW_CMD, OP_WRITE, REG_CONTROL, 8'h02, 8'h02);
		add_row(ROW_STROBE, OP_READ, 3, 8'h00, 0);
		add_row(ROW_CMD, OP_WRITE, REG_CONTROL, 8'h03, 8'h03);
		add_row(ROW_STROBE, OP_READ, 1, 8'h00, 1);
		add_row(ROW_STROBE, OP_READ, 2, 8'h00, 1);
		add_row(ROW_CMD, OP_WRITE, REG_CONTROL, 8'h07, 8'h03);
		add_row(ROW_CLEAR, OP_READ, 0, 8'h00, 1);
		add_row(ROW_STROBE, OP_READ, 3, 8'h00, 1);

		t = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			t++;
			if (t > 20) begin
				$display("Reset was never released");
				stop_fail();
			end
		end
		foreach (rows[i])
			run_row(rows[i]);
		repeat (10) @(negedge clk);
		if (timetag_top_inst.timetag_sva_inst.fail_count == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("A bound assertion on the DUT outputs failed");
			stop_fail();
		end
	end

endmodule

`default_nettype wire

// File: timetag.f
hw/timetag_pkg.sv
hw/tag_if.sv
hw/cmd_decoder.sv
hw/strobe_frontend.sv
hw/channel_tagger.sv
hw/record_merger.sv
hw/timetag_top.sv
bench/timetag_clkgen.sv
bench/timetag_sva.sv
bench/timetag_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := timetag_tb
FILELIST := timetag.f

SRCS := $(shell grep -v '^+' $(FILELIST))
OBJ_DIR := obj_dir
BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
